//--- jacobian_pkg.sv
/* Matrix engine shared types */

package jacobian_pkg;

	localparam int ELEM_W = 9;
	localparam int PROD_W = 18;
	localparam int ACC_W = 20;	// Three products plus sign
	localparam int N_ELEM = 9;	// 3x3, fixed

	typedef logic signed [ELEM_W-1:0] elem_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [5:0] wb_adr_t;
	typedef logic [31:0] wb_dat_t;

	// Row-major, e00 in the top bits
	typedef struct packed {
		elem_t e00, e01, e02;
		elem_t e10, e11, e12;
		elem_t e20, e21, e22;
	} mat_t;

	typedef struct packed {
		acc_t r00, r01, r02;
		acc_t r10, r11, r12;
		acc_t r20, r21, r22;
	} res_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_adr_t adr;
		wb_dat_t dat;
	} wb_req_t;

	typedef enum logic {MODE_MATRIX = 1'b0, MODE_ELEMENT = 1'b1} job_mode_e;

	typedef enum logic [2:0] {IDLE, CLEAR, FEED, DRAIN, DONE} core_state_e;

	// Word addresses
	localparam wb_adr_t ADR_A = 6'h00;
	localparam wb_adr_t ADR_B = 6'h09;
	localparam wb_adr_t ADR_CTRL = 6'h12;
	localparam wb_adr_t ADR_STAT = 6'h13;
	localparam wb_adr_t ADR_RES = 6'h14;

endpackage

//--- mult_array.sv
/* Pipelined signed multiplier bank */

module mult_array #(
	parameter int LANES = 9,
	parameter int MULT_LAT = 2
) (
	input logic clk,
	input logic reset,
	input logic en,
	input jacobian_pkg::elem_t a [LANES],
	input jacobian_pkg::elem_t b [LANES],
	output jacobian_pkg::prod_t p [LANES]
);

	import jacobian_pkg::*;

	// stage[0] takes the raw products
	prod_t stage [MULT_LAT][LANES];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < MULT_LAT; s++) begin
				for (int i = 0; i < LANES; i++) begin
					stage[s][i] <= '0;
				end
			end
		end else if (en) begin
			for (int i = 0; i < LANES; i++) begin
				stage[0][i] <= a[i] * b[i];	// Signed, 18-bit context
			end
			for (int s = 1; s < MULT_LAT; s++) begin
				stage[s] <= stage[s-1];
			end
		end
	end

	assign p = stage[MULT_LAT-1];

endmodule

//--- mat_mult.sv
/* 3x3 matrix product by outer products */

module mat_mult #(
	parameter int MULT_LAT = 2
) (
	input logic clk,
	input logic reset,
	input logic en,
	input logic clear,
	input jacobian_pkg::elem_t col_a [3],
	input jacobian_pkg::elem_t row_b [3],
	output jacobian_pkg::res_t result
);

	import jacobian_pkg::*;

	elem_t lane_a [N_ELEM];
	elem_t lane_b [N_ELEM];
	prod_t prod [N_ELEM];
	acc_t acc [N_ELEM];
	logic [MULT_LAT-1:0] beat_vld;	// Tracks beats through the multipliers
	logic mult_en;

	// Lane 3*i+j carries a(i,k) * b(k,j)
	always_comb begin
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				lane_a[3*i+j] = col_a[i];
				lane_b[3*i+j] = row_b[j];
			end
		end
	end

	// Keep stepping until the last beat has left the pipe
	assign mult_en = en | (|beat_vld);

	mult_array #(.LANES(N_ELEM), .MULT_LAT(MULT_LAT)) mult_array_i (
		.clk(clk),
		.reset(reset),
		.en(mult_en),
		.a(lane_a),
		.b(lane_b),
		.p(prod)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			beat_vld <= '0;
			for (int i = 0; i < N_ELEM; i++) begin
				acc[i] <= '0;
			end
		end else begin
			beat_vld[0] <= en;
			for (int s = 1; s < MULT_LAT; s++) begin
				beat_vld[s] <= beat_vld[s-1];
			end
			if (clear) begin
				for (int i = 0; i < N_ELEM; i++) begin
					acc[i] <= '0;
				end
			end else if (beat_vld[MULT_LAT-1]) begin
				for (int i = 0; i < N_ELEM; i++) begin
					acc[i] <= acc[i] + acc_t'(prod[i]);
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < N_ELEM; i++) begin
			result[(N_ELEM-1-i)*ACC_W +: ACC_W] = acc[i];	// r00 on top
		end
	end

	// A beat landing on a clear would be lost
	clear_vs_beat: assert property (@(posedge clk) disable iff (reset)
		!(clear && beat_vld[MULT_LAT-1]))
		else $error("mat_mult clear coincides with an arriving beat");

endmodule

//--- array_mult.sv
/* Element-wise 3x3 product */

module array_mult #(
	parameter int MULT_LAT = 2
) (
	input logic clk,
	input logic reset,
	input logic en,
	input logic valid_in,
	input jacobian_pkg::mat_t a,
	input jacobian_pkg::mat_t b,
	output jacobian_pkg::res_t result,
	output logic valid_out
);

	import jacobian_pkg::*;

	elem_t lane_a [N_ELEM];
	elem_t lane_b [N_ELEM];
	prod_t prod [N_ELEM];
	logic [MULT_LAT-1:0] vld;

	always_comb begin
		for (int i = 0; i < N_ELEM; i++) begin
			lane_a[i] = a[(N_ELEM-1-i)*ELEM_W +: ELEM_W];
			lane_b[i] = b[(N_ELEM-1-i)*ELEM_W +: ELEM_W];
		end
	end

	mult_array #(.LANES(N_ELEM), .MULT_LAT(MULT_LAT)) mult_array_i (
		.clk(clk),
		.reset(reset),
		.en(en),
		.a(lane_a),
		.b(lane_b),
		.p(prod)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			vld <= '0;
			valid_out <= 1'b0;
		end else if (en) begin
			vld[0] <= valid_in;
			for (int s = 1; s < MULT_LAT; s++) begin
				vld[s] <= vld[s-1];
			end
			valid_out <= vld[MULT_LAT-1];
		end
	end

	// Result register, loaded one cycle after the products come out
	always_ff @(posedge clk) begin
		if (en && vld[MULT_LAT-1]) begin
			for (int i = 0; i < N_ELEM; i++) begin
				result[(N_ELEM-1-i)*ACC_W +: ACC_W] <= acc_t'(prod[i]);	// Sign extend
			end
		end
	end

endmodule

//--- jacobian_core.sv
/* Job sequencer for the matrix engine */

module jacobian_core #(
	parameter int MULT_LAT = 2
) (
	input logic clk,
	input logic reset,
	input logic start,
	input jacobian_pkg::job_mode_e mode,
	input jacobian_pkg::mat_t mat_a,
	input jacobian_pkg::mat_t mat_b,
	output logic busy,
	output logic done,
	output jacobian_pkg::res_t result
);

	import jacobian_pkg::*;

	localparam int CNT_W = $clog2(MULT_LAT + 3);

	core_state_e state;
	job_mode_e job_mode;	// Latched at start
	logic [CNT_W-1:0] cnt;	// Beat index in FEED, cycle count in DRAIN
	logic [CNT_W-1:0] last_beat;
	elem_t col_a [3];
	elem_t row_b [3];
	logic mm_en, mm_clear, am_en, am_valid_in, am_valid;
	res_t mm_res, am_res;

	assign last_beat = (job_mode == MODE_MATRIX) ? CNT_W'(2) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			job_mode <= MODE_MATRIX;
			cnt <= '0;
		end else begin
			case (state)
				IDLE: if (start) begin
					state <= CLEAR;
					job_mode <= mode;
				end
				CLEAR: begin
					state <= FEED;
					cnt <= '0;
				end
				FEED: if (cnt == last_beat) begin
					state <= DRAIN;
					cnt <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
				DRAIN: if (cnt == CNT_W'(MULT_LAT)) begin
					state <= DONE;
				end else begin
					cnt <= cnt + 1'b1;
				end
				default: state <= IDLE;	// DONE
			endcase
		end
	end

	// Column k of A and row k of B for beat k
	always_comb begin
		case (cnt)
			CNT_W'(0): begin
				col_a = '{mat_a.e00, mat_a.e10, mat_a.e20};
				row_b = '{mat_b.e00, mat_b.e01, mat_b.e02};
			end
			CNT_W'(1): begin
				col_a = '{mat_a.e01, mat_a.e11, mat_a.e21};
				row_b = '{mat_b.e10, mat_b.e11, mat_b.e12};
			end
			default: begin
				col_a = '{mat_a.e02, mat_a.e12, mat_a.e22};
				row_b = '{mat_b.e20, mat_b.e21, mat_b.e22};
			end
		endcase
	end

	assign busy = (state != IDLE);
	assign done = (state == DONE);
	assign mm_clear = (state == CLEAR);
	assign mm_en = (state == FEED) && (job_mode == MODE_MATRIX);
	assign am_valid_in = (state == FEED) && (job_mode == MODE_ELEMENT);
	assign am_en = busy;
	assign result = (job_mode == MODE_MATRIX) ? mm_res : am_res;

	mat_mult #(.MULT_LAT(MULT_LAT)) mat_mult_i (
		.clk(clk), .reset(reset), .en(mm_en), .clear(mm_clear),
		.col_a(col_a), .row_b(row_b), .result(mm_res)
	);

	array_mult #(.MULT_LAT(MULT_LAT)) array_mult_i (
		.clk(clk), .reset(reset), .en(am_en), .valid_in(am_valid_in),
		.a(mat_a), .b(mat_b), .result(am_res), .valid_out(am_valid)
	);

	done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done held for two cycles");

	start_idle_only: assert property (@(posedge clk) disable iff (reset)
		(start && state != IDLE) |=> state != CLEAR)
		else $error("start restarted a running job");

	// Element result must land by the end of DRAIN
	elem_in_time: assert property (@(posedge clk) disable iff (reset)
		(done && job_mode == MODE_ELEMENT) |-> $past(am_valid))
		else $error("element result late for done");

endmodule

//--- jacobian_wb.sv
/* Wishbone register slave */

module jacobian_wb (
	input logic clk,
	input logic reset,
	input jacobian_pkg::wb_req_t wb_req,
	output jacobian_pkg::wb_dat_t wb_dat_o,
	output logic wb_ack,
	input logic busy,
	input logic core_done,
	input jacobian_pkg::res_t core_result,
	output jacobian_pkg::mat_t mat_a,
	output jacobian_pkg::mat_t mat_b,
	output logic start,
	output jacobian_pkg::job_mode_e mode
);

	import jacobian_pkg::*;

	wb_adr_t adr;
	wb_adr_t idx_a, idx_b, idx_r;
	logic access;
	logic in_a, in_b, in_res;
	logic done_q;	// Sticky until status is read
	res_t res_q;
	wb_dat_t rd_data;

	assign adr = wb_req.adr;
	assign access = wb_req.cyc && wb_req.stb && !wb_ack;	// First cycle only

	assign in_a = (adr < ADR_B);
	assign in_b = (adr >= ADR_B) && (adr < ADR_CTRL);
	assign in_res = (adr >= ADR_RES) && (adr < ADR_RES + N_ELEM);
	assign idx_a = adr - ADR_A;
	assign idx_b = adr - ADR_B;
	assign idx_r = adr - ADR_RES;

	always_comb begin
		rd_data = '0;	// Unmapped reads
		if (in_a) begin
			rd_data = wb_dat_t'(elem_t'(mat_a[(N_ELEM-1-idx_a)*ELEM_W +: ELEM_W]));
		end else if (in_b) begin
			rd_data = wb_dat_t'(elem_t'(mat_b[(N_ELEM-1-idx_b)*ELEM_W +: ELEM_W]));
		end else if (in_res) begin
			rd_data = wb_dat_t'(acc_t'(res_q[(N_ELEM-1-idx_r)*ACC_W +: ACC_W]));
		end else if (adr == ADR_CTRL) begin
			rd_data = {30'd0, mode, 1'b0};
		end else if (adr == ADR_STAT) begin
			rd_data = {30'd0, done_q, busy};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			wb_dat_o <= '0;
			mat_a <= '0;
			mat_b <= '0;
			mode <= MODE_MATRIX;
			start <= 1'b0;
			done_q <= 1'b0;
			res_q <= '0;
		end else begin
			wb_ack <= access;
			start <= 1'b0;
			if (access && wb_req.we && !busy) begin	// Acked but dropped while busy
				if (in_a) mat_a[(N_ELEM-1-idx_a)*ELEM_W +: ELEM_W] <= wb_req.dat[ELEM_W-1:0];
				if (in_b) mat_b[(N_ELEM-1-idx_b)*ELEM_W +: ELEM_W] <= wb_req.dat[ELEM_W-1:0];
				if (adr == ADR_CTRL) begin
					mode <= job_mode_e'(wb_req.dat[1]);
					start <= wb_req.dat[0];
				end
			end
			if (access && !wb_req.we) begin
				wb_dat_o <= rd_data;
				if (adr == ADR_STAT) done_q <= 1'b0;
			end
			if (core_done) begin	// Set wins over a same-cycle clear
				done_q <= 1'b1;
				res_q <= core_result;
			end
		end
	end

	ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> (wb_req.cyc && wb_req.stb))
		else $error("ack outside a bus cycle");

endmodule

//--- jacobian_top.sv
/* Matrix engine top level */

module jacobian_top #(
	parameter int MULT_LAT = 2
) (
	input logic clk,
	input logic reset,
	input jacobian_pkg::wb_req_t wb_req,
	output jacobian_pkg::wb_dat_t wb_dat_o,
	output logic wb_ack
);

	import jacobian_pkg::*;

	mat_t mat_a, mat_b;
	res_t core_result;
	job_mode_e mode;
	logic start;
	logic busy;
	logic core_done;

	// Register file and bus side
	jacobian_wb jacobian_wb_i (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack),
		.busy(busy),
		.core_done(core_done),
		.core_result(core_result),
		.mat_a(mat_a),
		.mat_b(mat_b),
		.start(start),
		.mode(mode)
	);

	jacobian_core #(.MULT_LAT(MULT_LAT)) jacobian_core_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.mode(mode),
		.mat_a(mat_a),
		.mat_b(mat_b),
		.busy(busy),
		.done(core_done),
		.result(core_result)
	);

endmodule

//--- jacobian_tb.sv
/* Matrix engine testbench */

module jacobian_tb;

	import jacobian_pkg::*;

	localparam int ROWS = 12;
	localparam int TIMEOUT_CYCLES = ROWS * 200 + 500;
	localparam int DRV_DLY = 5;	// Drive offset after the rising edge

	logic clk;
	logic reset;
	wb_req_t wb_req;
	wb_dat_t wb_dat_o;
	logic wb_ack;

	int tbl_a [ROWS][9];
	int tbl_b [ROWS][9];
	int tbl_exp [ROWS][9];
	job_mode_e tbl_mode [ROWS];
	int errors;
	int checks;
	int cycles;

	jacobian_top #(.MULT_LAT(2)) jacobian_top_i (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// Edge rows first and then random rows of alternating mode
	task automatic fill_table();
		int acc;
		for (int r = 0; r < ROWS; r++) begin
			tbl_mode[r] = (r < 4 || r % 2 == 0) ? MODE_MATRIX : MODE_ELEMENT;
			for (int i = 0; i < 9; i++) begin
				if (r == 0) begin
					tbl_a[r][i] = 0;
					tbl_b[r][i] = 0;
				end else if (r == 1) begin
					tbl_a[r][i] = (i % 4 == 0) ? 1 : 0;	// Identity
					tbl_b[r][i] = i * 57 - 201;
				end else if (r == 2) begin
					tbl_a[r][i] = 255;
					tbl_b[r][i] = 255;
				end else if (r == 3) begin
					tbl_a[r][i] = -256;
					tbl_b[r][i] = -256;
				end else begin
					tbl_a[r][i] = int'($urandom_range(511)) - 256;
					tbl_b[r][i] = int'($urandom_range(511)) - 256;
				end
			end
			// Reference model
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					if (tbl_mode[r] == MODE_MATRIX) begin
						acc = 0;
						for (int k = 0; k < 3; k++) begin
							acc += tbl_a[r][3*i+k] * tbl_b[r][3*k+j];
						end
					end else begin
						acc = tbl_a[r][3*i+j] * tbl_b[r][3*i+j];
					end
					tbl_exp[r][3*i+j] = acc;
				end
			end
		end
	endtask

	// Request held until ack is seen
	task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
		output wb_dat_t rdat);
		int waits;
		waits = 0;
		@(posedge clk);
		#DRV_DLY;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.adr = adr;
		wb_req.dat = dat;
		do begin
			@(posedge clk);
			#DRV_DLY;
			waits++;
		end while (!wb_ack);
		rdat = wb_dat_o;
		checks++;
		if (waits != 1) begin
			$display("Ack for address 0x%h came %0d cycles after the request", adr, waits);
			errors++;
		end
		@(posedge clk);
		#DRV_DLY;
		checks++;
		if (wb_ack) begin
			$display("Ack for address 0x%h stayed high for a second cycle", adr);
			errors++;
		end
		wb_req = '0;
	endtask

	task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
		wb_dat_t unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic read_reg(input wb_adr_t adr, output wb_dat_t dat);
		bus_cycle(1'b0, adr, '0, dat);
	endtask

	task automatic check_word(input string name, input wb_dat_t got, input wb_dat_t exp);
		checks++;
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_after_reset();
		wb_dat_t d;
		read_reg(ADR_STAT, d);
		check_word("wb_dat_o status", d, '0);
		read_reg(ADR_CTRL, d);
		check_word("wb_dat_o control", d, '0);
		for (int i = 0; i < 9; i++) begin
			read_reg(6'(ADR_A + i), d);
			check_word($sformatf("wb_dat_o A[%0d]", i), d, '0);
			read_reg(6'(ADR_B + i), d);
			check_word($sformatf("wb_dat_o B[%0d]", i), d, '0);
			read_reg(6'(ADR_RES + i), d);
			check_word($sformatf("wb_dat_o result[%0d]", i), d, '0);
		end
	endtask

	task automatic check_unmapped();
		wb_dat_t d;
		read_reg(6'h1d, d);
		check_word("wb_dat_o unmapped 0x1d", d, '0);
		read_reg(6'h3f, d);
		check_word("wb_dat_o unmapped 0x3f", d, '0);
	endtask

	task automatic run_row(input int r);
		wb_dat_t d;
		for (int i = 0; i < 9; i++) begin
			write_reg(6'(ADR_A + i), 32'(tbl_a[r][i]));
			write_reg(6'(ADR_B + i), 32'(tbl_b[r][i]));
		end
		write_reg(ADR_CTRL, {30'd0, tbl_mode[r], 1'b1});
		if (tbl_mode[r] == MODE_MATRIX) begin
			// Writes while busy get acked but dropped
			read_reg(ADR_STAT, d);
			check_word($sformatf("wb_dat_o busy bit, row %0d", r), {31'd0, d[0]}, 32'd1);
			write_reg(6'(ADR_A + 4), 32'(~tbl_a[r][4]));
			write_reg(ADR_CTRL, 32'h3);	// Element-mode restart
		end
		do begin
			read_reg(ADR_STAT, d);
		end while (!d[1]);
		read_reg(ADR_STAT, d);	// Sticky done now clear
		check_word($sformatf("wb_dat_o status after done, row %0d", r), d, '0);
		for (int i = 0; i < 9; i++) begin
			read_reg(6'(ADR_RES + i), d);
			check_word($sformatf("wb_dat_o result[%0d], row %0d", i, r), d,
				32'(tbl_exp[r][i]));
		end
		if (tbl_mode[r] == MODE_MATRIX) begin
			read_reg(6'(ADR_A + 4), d);
			check_word($sformatf("wb_dat_o A[4], row %0d", r), d, 32'(tbl_a[r][4]));
			read_reg(ADR_CTRL, d);
			check_word($sformatf("wb_dat_o control, row %0d", r), d, '0);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		wb_req = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		void'($urandom(55542));
		fill_table();
		repeat (3) @(posedge clk);
		#DRV_DLY;
		reset = 1'b0;
		check_after_reset();
		check_unmapped();
		for (int r = 0; r < ROWS; r++) begin
			run_row(r);
		end
		check_unmapped();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- jacobian_top.f
jacobian_pkg.sv
mult_array.sv
mat_mult.sv
array_mult.sv
jacobian_core.sv
jacobian_wb.sv
jacobian_top.sv
jacobian_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the matrix engine testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module jacobian_tb \
	-f jacobian_top.f -o jacobian_sim > build.log 2>&1 &&
./obj_dir/jacobian_sim > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
